// ==== dv/dma_resp_tb.sv ====
/* DMA response initiator testbench
   Random NoC response packets, AHB beat, done event and memory checks */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_resp_tb
  import dma_pkg::*;
();

  localparam int N_PKT     = 40;
  localparam int MAX_LEN   = 6;              // Data words per R2L packet
  localparam int MAX_FLITS = 3 + MAX_LEN;    // Header, size, address, data
  localparam int MEM_WORDS = 1024;
  localparam int WD_CYCLES = N_PKT * MAX_FLITS * 20;
  localparam int KIND_L2R  = 0;
  localparam int KIND_R2L  = 1;
  localparam int KIND_UNK  = 2;              // Type code the DUT drops

  typedef struct packed {
    logic        nonseq;                     // First beat of a packet
    logic [31:0] addr;
    logic [31:0] data;
  } beat_t;

  logic                            clk = 1'b0;
  logic                            rst;
  flit_t                           noc_in;
  logic                            noc_in_valid;
  logic                            noc_in_ready;
  logic                            ahb_hready;
  ahb_wr_t                         ahb_wr;
  done_evt_t                       done_evt;
  logic                            clr_en;
  logic [`DMA_TABLE_PTR_WIDTH-1:0] clr_pos;
  logic [`DMA_TABLE_ENTRIES-1:0]   done_vec;

  integer                          seed;
  int                              err_cnt   = 0;
  int                              beat_cnt  = 0;
  int                              done_seen = 0;
  logic                            auto_clear = 1'b0;
  logic                            mem_hold   = 1'b0;  // Holds hready low
  logic [`DMA_TABLE_ENTRIES-1:0]   vec_model  = '0;   // Expected done vector

  // Packet list and its flit stream
  int          pkt_kind [N_PKT];
  logic [1:0]  pkt_id   [N_PKT];
  logic        pkt_last [N_PKT];
  logic [31:0] pkt_base [N_PKT];
  int          pkt_len  [N_PKT];
  logic [31:0] pkt_data [N_PKT][MAX_LEN];
  int          flit_start [N_PKT+1];
  flit_t       flits [$];

  // Reference results
  logic [31:0] exp_mem [MEM_WORDS];
  beat_t       exp_beats [$];
  logic [1:0]  exp_done [$];

  always #4 clk = ~clk;

  dma_resp_initiator u_dut (
    .clk          (clk),
    .rst          (rst),
    .noc_in       (noc_in),
    .noc_in_valid (noc_in_valid),
    .noc_in_ready (noc_in_ready),
    .ahb_hready   (ahb_hready),
    .ahb_wr       (ahb_wr),
    .done_evt     (done_evt),
    .clr_en       (clr_en),
    .clr_pos      (clr_pos),
    .done_vec     (done_vec)
  );

  tb_ahb_mem #(.WORDS(MEM_WORDS), .SEED(32'hf7d3627e)) u_mem (
    .clk    (clk),
    .rst    (rst),
    .hold   (mem_hold),
    .ahb_wr (ahb_wr),
    .hready (ahb_hready)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERROR %0t ns %s: got %h, expected %h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  function automatic logic [31:0] hdr_word(input logic [1:0] ptype, input logic [1:0] id,
                                           input logic last);
    resp_hdr_t h;
    h           = '0;
    h.pkt_type  = ptype;
    h.table_id  = id;
    h.resp_last = last;
    return h;
  endfunction

  function automatic flit_t make_flit(input logic [1:0] ftype, input logic [31:0] word);
    flit_t f;
    f.ftype        = ftype;
    f.content.word = word;
    return f;
  endfunction

  ////////////////////////////////////////////////
  // Packet list from a fixed seed
  ////////////////////////////////////////////////

  task automatic build_packets();
    logic        open;
    logic [1:0]  next_id;
    logic [31:0] addr;
    logic [1:0]  ftype;
    int          r;
    open    = 1'b0;
    next_id = '0;
    addr    = 32'h40;
    for (int p = 0; p < N_PKT; p++) begin
      r = $random(seed) & 15;
      if (open) begin
        pkt_kind[p] = KIND_R2L;              // Open response keeps its id
        pkt_id[p]   = pkt_id[p-1];
      end else begin
        if (p < 4) pkt_kind[p] = KIND_L2R;   // Entries 0..3 in turn
        else if (p == 4 || r > 4) pkt_kind[p] = KIND_R2L;
        else if (r == 4) pkt_kind[p] = KIND_UNK;
        else pkt_kind[p] = KIND_L2R;
        pkt_id[p] = next_id;
        if (pkt_kind[p] != KIND_UNK) next_id = next_id + 1'b1;  // Round robin
      end
      // Packet 4 leaves its response open and packet 5 closes it
      pkt_last[p] = (p == 5 || p == N_PKT - 1) ? 1'b1 : (p == 4) ? 1'b0 : r[0];
      open        = (pkt_kind[p] == KIND_R2L) && !pkt_last[p];
      pkt_len[p]  = 1 + (($random(seed) & 32'h7fff_ffff) % MAX_LEN);
      pkt_base[p] = addr;
      if (pkt_kind[p] == KIND_R2L) addr = addr + 32'(4 * (pkt_len[p] + (r & 3)));
      for (int w = 0; w < MAX_LEN; w++) pkt_data[p][w] = $random(seed);
      flit_start[p] = flits.size();
      case (pkt_kind[p])
        KIND_R2L: begin
          flits.push_back(make_flit(`DMA_FLIT_FIRST,
                                    hdr_word(`DMA_PKT_R2L_RESP, pkt_id[p], pkt_last[p])));
          flits.push_back(make_flit(`DMA_FLIT_MIDDLE, 32'(pkt_len[p])));   // Size
          flits.push_back(make_flit(`DMA_FLIT_MIDDLE, pkt_base[p]));
          for (int w = 0; w < pkt_len[p]; w++) begin
            ftype = (w == pkt_len[p] - 1) ? `DMA_FLIT_LAST : `DMA_FLIT_MIDDLE;
            flits.push_back(make_flit(ftype, pkt_data[p][w]));
          end
        end
        KIND_L2R: flits.push_back(make_flit(`DMA_FLIT_SINGLE,
                                            hdr_word(`DMA_PKT_L2R_RESP, pkt_id[p], 1'b1)));
        default:  flits.push_back(make_flit(`DMA_FLIT_SINGLE, hdr_word(2'b00, pkt_id[p], 1'b1)));
      endcase
    end
    flit_start[N_PKT] = flits.size();
  endtask

  // Expected beats, done events and final memory from the packet list
  function automatic void build_expected();
    beat_t b;
    for (int i = 0; i < MEM_WORDS; i++) exp_mem[i] = {~i[15:0], i[15:0]};  // Untouched fill
    for (int p = 0; p < N_PKT; p++) begin
      if (pkt_kind[p] == KIND_L2R) exp_done.push_back(pkt_id[p]);
      if (pkt_kind[p] == KIND_R2L) begin
        for (int w = 0; w < pkt_len[p]; w++) begin
          b.nonseq = (w == 0);
          b.addr   = pkt_base[p] + 32'(4 * w);
          b.data   = pkt_data[p][w];
          exp_beats.push_back(b);
          exp_mem[b.addr[11:2]] = b.data;
        end
        if (pkt_last[p]) exp_done.push_back(pkt_id[p]);
      end
    end
  endfunction

  // Flits lo..hi-1 with random idle gaps
  task automatic send_range(input int lo, input int hi);
    for (int i = lo; i < hi; i++) begin
      while ((($random(seed) & 3) == 0) || !noc_in_ready) begin
        noc_in_valid = 1'b0;
        @(negedge clk);
      end
      noc_in_valid = 1'b1;
      noc_in       = flits[i];
      @(negedge clk);
    end
    noc_in_valid = 1'b0;
  endtask

  task automatic check_beat();
    beat_t b;
    beat_cnt++;
    if (exp_beats.size() == 0) begin
      $display("Unexpected write beat to %h at %0t ns", ahb_wr.haddr, $time);
      err_cnt++;
    end else begin
      b = exp_beats.pop_front();
      check("haddr", ahb_wr.haddr, b.addr);
      check("hwdata", ahb_wr.hwdata, b.data);
      check("htrans", 32'(ahb_wr.htrans), b.nonseq ? `DMA_HTRANS_NONSEQ : `DMA_HTRANS_SEQ);
      check("hburst", 32'(ahb_wr.hburst), `DMA_HBURST_INCR);
      check("hwrite", 32'(ahb_wr.hwrite), 1);
      check("hmastlock", 32'(ahb_wr.hmastlock), 1);
    end
  endtask

  task automatic check_done();
    logic [1:0] want;
    if (exp_done.size() == 0) begin
      $display("Unexpected done event for entry %0d at %0t ns", done_evt.pos, $time);
      err_cnt++;
    end else begin
      want = exp_done.pop_front();
      check("done_evt.pos", 32'(done_evt.pos), 32'(want));
      vec_model[want] = 1'b1;
      done_seen++;
    end
  endtask

  ////////////////////////////////////////////////
  // Comparison at the rising edge
  ////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      if (ahb_wr.hsel && ahb_hready) check_beat();
      if (clr_en) vec_model[clr_pos] = 1'b0;
      if (done_evt.valid) check_done();   // Set wins over a same-cycle clear
    end
  end

  // Vector compare and host clears on the falling edge
  always @(negedge clk) begin
    check("done_vec", 32'(done_vec), 32'(vec_model));
    if (auto_clear) begin
      clr_en  = |vec_model;
      clr_pos = '0;
      for (int i = `DMA_TABLE_ENTRIES - 1; i >= 0; i--) begin
        if (vec_model[i]) clr_pos = 2'(i);   // Lowest set entry
      end
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d beats and %0d done events pending",
             WD_CYCLES, exp_beats.size(), exp_done.size());
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int fill_end;
    seed         = 32'hf7d3627e;
    rst          = 1'b1;
    noc_in       = '0;
    noc_in_valid = 1'b0;
    clr_en       = 1'b0;
    clr_pos      = '0;
    build_packets();
    build_expected();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    check("hsel", 32'(ahb_wr.hsel), 0);
    check("hmastlock", 32'(ahb_wr.hmastlock), 0);
    check("done_evt.valid", 32'(done_evt.valid), 0);
    check("done_vec", 32'(done_vec), 0);

    // One L2R per entry then a lone clear of entry 2
    send_range(flit_start[0], flit_start[4]);
    while (done_seen < 4) @(negedge clk);
    check("done_vec", 32'(done_vec), 32'hf);
    clr_en  = 1'b1;
    clr_pos = 2'd2;
    @(negedge clk);
    clr_en = 1'b0;
    check("done_vec", 32'(done_vec), 32'hb);
    @(posedge clk);
    auto_clear = 1'b1;
    while (vec_model != '0) @(negedge clk);

    // Wait states held so the first data flit blocks and the buffer fills
    fill_end = flit_start[4] + 3 + `DMA_PKT_BUF_DEPTH;   // Header, size, address popped
    mem_hold = 1'b1;
    send_range(flit_start[4], fill_end);
    check("noc_in_ready", 32'(noc_in_ready), 0);
    mem_hold = 1'b0;

    send_range(fill_end, flit_start[N_PKT]);
    while (exp_beats.size() != 0 || exp_done.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);            // Room for a stray beat
    for (int i = 0; i < MEM_WORDS; i++) begin
      check($sformatf("mem[%0d]", i), u_mem.mem[i], exp_mem[i]);
    end

    $display("Run complete: %0d errors, %0d beats, %0d done events",
             err_cnt, beat_cnt, done_seen);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_ahb_mem.sv ====
/* AHB-Lite write slave model
   Word memory behind random wait states on hready */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module tb_ahb_mem
  import dma_pkg::*;
#(
  parameter int          WORDS = 1024,
  parameter logic [31:0] SEED  = 32'hf7d3627e
) (
  input  wire          clk,
  input  wire          rst,
  input  wire          hold,      // Forces wait states
  input  wire ahb_wr_t ahb_wr,
  output logic         hready
);

  localparam int IDX_W = $clog2(WORDS);

  logic [31:0]      mem [WORDS];
  logic             stall = 1'b0;
  logic [IDX_W-1:0] idx;          // Word index from byte address
  integer           seed;

  // Fill word built from the whole index
  initial begin
    int i;
    seed = SEED;
    for (i = 0; i < WORDS; i++) begin
      mem[i] = {~i[15:0], i[15:0]};
    end
  end

  ////////////////////////////////////////////////
  // Wait states and write port
  ////////////////////////////////////////////////

  assign hready = !stall && !hold;
  assign idx    = ahb_wr.haddr[IDX_W+1:2];

  always @(negedge clk) begin
    stall <= !rst && (($random(seed) & 3) == 0);   // About one cycle in four
  end

  // Address and data phase in one cycle
  always @(posedge clk) begin
    if (!rst && ahb_wr.hsel && ahb_wr.hwrite && ahb_wr.htrans[1] && hready) begin
      mem[idx] <= ahb_wr.hwdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_addr_counter.sv ====
/* Write-address and beat counter
   Loaded from the address flit, stepped once per completed beat */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_addr_counter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        load,        // New packet base
  input  wire [`DMA_ADDR_WIDTH-1:0]  base,
  input  wire                        step,        // Beat done
  output logic [`DMA_ADDR_WIDTH-1:0] addr,
  output logic                       first_beat
);

  // Word count spanning the whole address space
  logic [`DMA_ADDR_WIDTH-3:0] beat_cnt;

  ////////////////////////////////////////////////
  // Address register
  ////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      addr <= base;
    end else if (step) begin
      addr <= addr + `DMA_ADDR_WIDTH'(4);  // Next word
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (load) begin
      beat_cnt <= '0;
    end else if (step) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign first_beat = (beat_cnt == '0);   // Selects NONSEQ

  a_load_step_excl: assert property (@(posedge clk) disable iff (rst)
    !(load && step))
    else $error("address counter load and step together");

endmodule

`default_nettype wire

// ==== logic/dma_defines.svh ====
/* DMA response initiator
   Shared widths, flit and packet type codes, AHB encodings, buffer depth */

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Bus and flit widths
`define DMA_ADDR_WIDTH          32
`define DMA_FLIT_TYPE_WIDTH     2
`define DMA_FLIT_WIDTH          34   // Type above content
`define DMA_FLIT_CONTENT_WIDTH  `DMA_ADDR_WIDTH

// Transfer table
`define DMA_TABLE_ENTRIES       4
`define DMA_TABLE_PTR_WIDTH     2

// Packet buffer depth in flits
`define DMA_PKT_BUF_DEPTH       16

// Flit type codes
`define DMA_FLIT_MIDDLE         2'b00
`define DMA_FLIT_FIRST          2'b01
`define DMA_FLIT_LAST           2'b10
`define DMA_FLIT_SINGLE         2'b11

// Header fields with packet type on top
`define DMA_PKT_TYPE_WIDTH      2
`define DMA_HDR_RSVD_WIDTH      27   // 32 - type - id - last flag
`define DMA_PKT_L2R_RESP        2'b10
`define DMA_PKT_R2L_RESP        2'b11

// AHB-Lite encodings
`define DMA_HTRANS_IDLE         2'b00
`define DMA_HTRANS_NONSEQ       2'b10
`define DMA_HTRANS_SEQ          2'b11
`define DMA_HBURST_INCR         3'b001

`endif

// ==== logic/dma_done_table.sv ====
/* Transfer table done vector
   One sticky bit per entry, set by done events, cleared by the host */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_done_table
  import dma_pkg::*;
(
  input  wire                            clk,
  input  wire                            rst,

  // From the response FSM
  input  wire done_evt_t                 done_evt,

  // Host clear
  input  wire                            clr_en,
  input  wire [`DMA_TABLE_PTR_WIDTH-1:0] clr_pos,

  output logic [`DMA_TABLE_ENTRIES-1:0]  done_vec
);

  ////////////////////////////////////////////////
  // Sticky bits
  ////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      done_vec <= '0;
    end else begin
      if (clr_en) begin
        done_vec[clr_pos] <= 1'b0;
      end
      // Set comes last and wins a same-entry clash
      if (done_evt.valid) begin
        done_vec[done_evt.pos] <= 1'b1;
      end
    end
  end

  // Entry must be cleared before it completes again
  a_no_double_done: assert property (@(posedge clk) disable iff (rst)
    done_evt.valid |-> !done_vec[done_evt.pos])
    else $error("done event for entry %0d already set", done_evt.pos);

endmodule

`default_nettype wire

// ==== logic/dma_packet_buffer.sv ====
/* Flit FIFO between the NoC link and the response FSM
   Circular buffer, one push and one pop per cycle */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_packet_buffer
  import dma_pkg::*;
(
  input  wire   clk,
  input  wire   rst,

  // NoC side
  input  wire flit_t in_flit,
  input  wire   in_valid,
  output logic  in_ready,

  // FSM side
  output flit_t out_flit,
  output logic  out_valid,
  input  wire   out_ready
);

  localparam int DEPTH = `DMA_PKT_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  ////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////

  logic [`DMA_FLIT_WIDTH-1:0] mem [DEPTH];  // Raw flit words
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [PTR_W:0]             count;        // Occupancy 0..DEPTH

  logic push;
  logic pop;
  logic full;
  logic empty;

  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);

  assign in_ready  = !full;   // Only back-pressure is full
  assign out_valid = !empty;
  assign out_flit  = flit_t'(mem[rd_ptr]);  // Head of queue

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Payload write
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_flit;
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};  // Unchanged when both
    end
  end

  // Neither side may move a flit past the limits
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    in_valid && in_ready |-> count < (PTR_W + 1)'(DEPTH))
    else $error("packet buffer write while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> count != '0)
    else $error("packet buffer read while empty");

endmodule

`default_nettype wire

// ==== logic/dma_pkg.sv ====
/* DMA response initiator types
   Flit layout, header view, AHB write request and done event */

`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

  ////////////////////////////////////////////////
  // Response header in the first flit of a packet
  ////////////////////////////////////////////////

  typedef struct packed {
    logic [`DMA_PKT_TYPE_WIDTH-1:0]  pkt_type;   // L2R or R2L response
    logic [`DMA_TABLE_PTR_WIDTH-1:0] table_id;   // Transfer table entry
    logic                            resp_last;  // Last packet of response
    logic [`DMA_HDR_RSVD_WIDTH-1:0]  rsvd;
  } resp_hdr_t;

  // Same 32 bits read as header or plain word
  typedef union packed {
    resp_hdr_t                          hdr;
    logic [`DMA_FLIT_CONTENT_WIDTH-1:0] word;  // Address or data
  } flit_content_u;

  typedef struct packed {
    logic [`DMA_FLIT_TYPE_WIDTH-1:0] ftype;    // FIRST/MIDDLE/LAST/SINGLE
    flit_content_u                   content;
  } flit_t;

  ////////////////////////////////////////////////
  // Outbound AHB-Lite write request
  ////////////////////////////////////////////////

  typedef struct packed {
    logic                       hsel;
    logic                       hwrite;
    logic                       hmastlock;
    logic [1:0]                 htrans;
    logic [2:0]                 hburst;
    logic [`DMA_ADDR_WIDTH-1:0] haddr;
    logic [`DMA_ADDR_WIDTH-1:0] hwdata;
  } ahb_wr_t;

  // One-cycle completion pulse for a table entry
  typedef struct packed {
    logic                            valid;
    logic [`DMA_TABLE_PTR_WIDTH-1:0] pos;
  } done_evt_t;

endpackage

`default_nettype wire

// ==== logic/dma_resp_fsm.sv ====
/* Response FSM
   Decodes packet headers, sequences AHB write beats, flags completions */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_resp_fsm
  import dma_pkg::*;
(
  input  wire        clk,
  input  wire        rst,

  // Packet buffer
  input  wire flit_t buf_flit,
  input  wire        buf_valid,
  output logic       buf_ready,

  // AHB-Lite write master
  input  wire        ahb_hready,
  output ahb_wr_t    ahb_wr,

  // Address counter
  input  wire [`DMA_ADDR_WIDTH-1:0] cnt_addr,
  input  wire        cnt_first_beat,
  output logic       cnt_load,
  output logic       cnt_step,

  // Completion pulse
  output done_evt_t  done_evt
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GET_SIZE,
    ST_GET_ADDR,
    ST_DATA
  } state_t;

  state_t state;
  state_t nxt_state;

  logic [`DMA_TABLE_PTR_WIDTH-1:0] resp_id;    // Entry of current packet
  logic [`DMA_TABLE_PTR_WIDTH-1:0] nxt_resp_id;
  logic                            resp_last;  // Header's last flag
  logic                            nxt_resp_last;
  logic                            last_flit;

  // LAST closes a multi-flit packet, SINGLE a lone data flit
  assign last_flit = (buf_flit.ftype == `DMA_FLIT_LAST) ||
                     (buf_flit.ftype == `DMA_FLIT_SINGLE);

  ////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////

  always_comb begin
    nxt_state     = state;
    nxt_resp_id   = resp_id;
    nxt_resp_last = resp_last;
    buf_ready     = 1'b0;
    cnt_load      = 1'b0;
    cnt_step      = 1'b0;
    done_evt      = '0;
    ahb_wr        = '0;
    ahb_wr.haddr  = cnt_addr;               // Address and data phase together
    ahb_wr.hwdata = buf_flit.content.word;

    case (state)
      ST_IDLE: begin
        buf_ready = 1'b1;                   // Headers always drain
        if (buf_valid) begin
          nxt_resp_id   = buf_flit.content.hdr.table_id;
          nxt_resp_last = buf_flit.content.hdr.resp_last;
          if (buf_flit.content.hdr.pkt_type == `DMA_PKT_L2R_RESP) begin
            done_evt.valid = 1'b1;          // Single flit completes at once
            done_evt.pos   = buf_flit.content.hdr.table_id;
          end else if (buf_flit.content.hdr.pkt_type == `DMA_PKT_R2L_RESP) begin
            nxt_state = ST_GET_SIZE;
          end
          // Unknown type dropped
        end
      end

      ST_GET_SIZE: begin
        buf_ready = 1'b1;                   // Size word unused
        if (buf_valid) nxt_state = ST_GET_ADDR;
      end

      ST_GET_ADDR: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          cnt_load  = 1'b1;                 // Base from flit word
          nxt_state = ST_DATA;
        end
      end

      ST_DATA: begin
        ahb_wr.hmastlock = 1'b1;            // Locked for whole sequence
        ahb_wr.hburst    = `DMA_HBURST_INCR;
        if (buf_valid) begin
          ahb_wr.hsel   = 1'b1;
          ahb_wr.hwrite = 1'b1;
          ahb_wr.htrans = cnt_first_beat ? `DMA_HTRANS_NONSEQ : `DMA_HTRANS_SEQ;
        end
        buf_ready = ahb_hready;             // Hold flit through wait states
        if (buf_valid && ahb_hready) begin
          cnt_step = 1'b1;
          if (last_flit) begin
            nxt_state = ST_IDLE;
            if (resp_last) begin
              done_evt.valid = 1'b1;
              done_evt.pos   = resp_id;
            end
          end
        end
      end

      default: nxt_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      resp_id   <= '0;
      resp_last <= 1'b0;
    end else begin
      state     <= nxt_state;
      resp_id   <= nxt_resp_id;
      resp_last <= nxt_resp_last;
    end
  end

  a_hsel_in_data: assert property (@(posedge clk) disable iff (rst)
    ahb_wr.hsel |-> state == ST_DATA)
    else $error("hsel outside data state");

  // Stalled beat keeps address and data until hready returns
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    ahb_wr.hsel && !ahb_hready |=>
      ahb_wr.hsel && $stable(ahb_wr.haddr) && $stable(ahb_wr.hwdata))
    else $error("beat changed during wait state");

endmodule

`default_nettype wire

// ==== logic/dma_resp_initiator.sv ====
/* DMA response initiator
   NoC response packets in, AHB-Lite write beats and completion status out */

`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_resp_initiator
  import dma_pkg::*;
(
  input  wire                            clk,
  input  wire                            rst,

  // NoC link
  input  wire flit_t                     noc_in,
  input  wire                            noc_in_valid,
  output logic                           noc_in_ready,

  // AHB-Lite write master
  input  wire                            ahb_hready,
  output ahb_wr_t                        ahb_wr,

  // Completion
  output done_evt_t                      done_evt,
  input  wire                            clr_en,
  input  wire [`DMA_TABLE_PTR_WIDTH-1:0] clr_pos,
  output logic [`DMA_TABLE_ENTRIES-1:0]  done_vec
);

  ////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////

  flit_t                      buf_flit;   // Head of packet buffer
  logic                       buf_valid;
  logic                       buf_ready;
  logic                       cnt_load;
  logic                       cnt_step;
  logic [`DMA_ADDR_WIDTH-1:0] cnt_addr;   // Current beat address
  logic                       cnt_first_beat;

  dma_packet_buffer u_buf (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  dma_resp_fsm u_fsm (
    .clk            (clk),
    .rst            (rst),
    .buf_flit       (buf_flit),
    .buf_valid      (buf_valid),
    .buf_ready      (buf_ready),
    .ahb_hready     (ahb_hready),
    .ahb_wr         (ahb_wr),
    .cnt_addr       (cnt_addr),
    .cnt_first_beat (cnt_first_beat),
    .cnt_load       (cnt_load),
    .cnt_step       (cnt_step),
    .done_evt       (done_evt)
  );

  // Base comes straight from the address flit word
  dma_addr_counter u_cnt (
    .clk        (clk),
    .rst        (rst),
    .load       (cnt_load),
    .base       (buf_flit.content.word),
    .step       (cnt_step),
    .addr       (cnt_addr),
    .first_beat (cnt_first_beat)
  );

  dma_done_table u_done (
    .clk      (clk),
    .rst      (rst),
    .done_evt (done_evt),
    .clr_en   (clr_en),
    .clr_pos  (clr_pos),
    .done_vec (done_vec)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA response testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module dma_resp_tb -f sources.f -o dma_resp_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/dma_resp_sim > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+logic
logic/dma_pkg.sv
logic/dma_packet_buffer.sv
logic/dma_addr_counter.sv
logic/dma_resp_fsm.sv
logic/dma_done_table.sv
logic/dma_resp_initiator.sv
dv/tb_ahb_mem.sv
dv/dma_resp_tb.sv
